// ==== src/conv_ctrl_defs.svh ====
`ifndef CONV_CTRL_DEFS_SVH
`define CONV_CTRL_DEFS_SVH

`define CC_SYSTOLIC_SIZE 4
`define CC_KERNEL_SIZE   3
`define CC_IFM_CHANNEL   1
`define CC_OFM_SIZE      4
`define CC_NO_FILTER     8

// One weight or IFM feed covers the whole kernel volume.
`define CC_LOAD_CYCLES   (`CC_KERNEL_SIZE * `CC_KERNEL_SIZE * `CC_IFM_CHANNEL)
`define CC_WINDOW_CYCLES (`CC_LOAD_CYCLES + 2 * `CC_SYSTOLIC_SIZE)
`define CC_DRAIN_CYCLES  (`CC_SYSTOLIC_SIZE + 2)
// Tiles per pass must stay even so that the pooling pairs close.
`define CC_NO_TILING     (((`CC_OFM_SIZE + `CC_SYSTOLIC_SIZE - 1) / `CC_SYSTOLIC_SIZE) * `CC_OFM_SIZE)
`define CC_NO_PASS       ((`CC_NO_FILTER + `CC_SYSTOLIC_SIZE - 1) / `CC_SYSTOLIC_SIZE)

`define CC_WB_AW 2
`define CC_WB_DW 32

`endif

// ==== src/conv_ctrl_pkg.sv ====
`include "conv_ctrl_defs.svh"

package conv_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOAD_WEIGHT = 3'd1,
        FIRST_TILE  = 3'd2,
        STREAM      = 3'd3,
        DRAIN       = 3'd4
    } phase_t;

    typedef logic [4:0] step_t;
    typedef logic [7:0] tile_t;
    typedef logic [3:0] pass_t;
    typedef logic [$clog2(`CC_SYSTOLIC_SIZE + 1)-1:0] wgt_size_t;
    typedef logic [`CC_SYSTOLIC_SIZE-1:0] col_mask_t;

    typedef enum logic [`CC_WB_AW-1:0] {
        REG_CTRL     = 2'd0,
        REG_WGT_SIZE = 2'd1,
        REG_STATUS   = 2'd2,
        REG_RSVD     = 2'd3
    } reg_addr_t;

endpackage

// ==== src/ctrl_regs.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module ctrl_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`CC_WB_AW-1:0]     wb_adr,
    input  logic [`CC_WB_DW-1:0]     wb_dat_w,
    output logic [`CC_WB_DW-1:0]     wb_dat_r,
    output logic                     wb_ack,
    input  logic                     busy,
    input  logic                     done,
    output logic                     start,
    output conv_ctrl_pkg::wgt_size_t wgt_size
);
    import conv_ctrl_pkg::*;

    logic                 req;
    logic                 wr;
    reg_addr_t            addr;
    logic                 done_flag;
    logic [`CC_WB_DW-1:0] rd_data;

    assign req  = wb_cyc && wb_stb && !wb_ack; // Single wait state per access.
    assign wr   = req && wb_we;
    assign addr = reg_addr_t'(wb_adr);

    always_comb begin
        rd_data = '0;
        case (addr)
            REG_WGT_SIZE: rd_data[$bits(wgt_size_t)-1:0] = wgt_size;
            REG_STATUS:   rd_data[1:0] = {done_flag, busy};
            default:      rd_data = '0; // CTRL and the reserved slot read zero.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            wgt_size  <= wgt_size_t'(`CC_SYSTOLIC_SIZE);
            done_flag <= 1'b0;
        end else begin
            wb_ack <= req;
            start  <= wr && (addr == REG_CTRL) && wb_dat_w[0];
            if (wr && (addr == REG_WGT_SIZE)) begin
                wgt_size <= wb_dat_w[$bits(wgt_size_t)-1:0];
            end
            if (done) begin
                done_flag <= 1'b1; // A new pulse wins over a clear in the same cycle.
            end else if (wr && (addr == REG_STATUS) && wb_dat_w[1]) begin
                done_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// ==== src/phase_sequencer.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module phase_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output conv_ctrl_pkg::phase_t next_phase,
    output conv_ctrl_pkg::step_t  step,
    output conv_ctrl_pkg::tile_t  tile,
    output conv_ctrl_pkg::pass_t  filter_pass,
    output logic                  busy,
    output logic                  done
);
    import conv_ctrl_pkg::*;

    phase_t phase_q;
    step_t  step_q;
    tile_t  tile_q;
    logic   in_window;
    logic   win_end;
    logic   last_pass;

    assign in_window = (phase_q == FIRST_TILE) || (phase_q == STREAM);
    assign win_end   = in_window && (step_q == step_t'(`CC_WINDOW_CYCLES - 1));
    assign last_pass = (filter_pass == pass_t'(`CC_NO_PASS));
    assign busy      = (phase_q != IDLE);

    always_comb begin
        next_phase = phase_q;
        case (phase_q)
            IDLE: if (start) next_phase = LOAD_WEIGHT; // Start is ignored in any other phase.
            LOAD_WEIGHT: begin
                if (step_q == step_t'(`CC_LOAD_CYCLES - 1)) next_phase = FIRST_TILE;
            end
            FIRST_TILE: if (win_end) next_phase = STREAM;
            STREAM: begin
                if (win_end && (tile_q == tile_t'(`CC_NO_TILING - 1))) next_phase = DRAIN;
            end
            DRAIN: begin
                if (step_q == step_t'(`CC_DRAIN_CYCLES - 1)) begin
                    next_phase = last_pass ? IDLE : LOAD_WEIGHT;
                end
            end
            default: next_phase = IDLE;
        endcase
    end

    // Step and tile are presented for the cycle that next_phase describes.
    always_comb begin
        step = step_q + 1'b1;
        if ((next_phase != phase_q) || (next_phase == IDLE) || win_end) begin
            step = '0;
        end
    end

    always_comb begin
        tile = tile_q;
        if ((next_phase == FIRST_TILE) && (phase_q != FIRST_TILE)) begin
            tile = '0;
        end else if (win_end) begin
            tile = tile_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q     <= IDLE;
            step_q      <= '0;
            tile_q      <= '0;
            filter_pass <= '0;
            done        <= 1'b0;
        end else begin
            phase_q <= next_phase;
            step_q  <= step;
            tile_q  <= tile;
            if ((phase_q == IDLE) && start) begin
                filter_pass <= '0;
            end else if ((phase_q == LOAD_WEIGHT) && (next_phase == FIRST_TILE)) begin
                filter_pass <= filter_pass + 1'b1;
            end
            done <= (next_phase == DRAIN) && (step == step_t'(`CC_DRAIN_CYCLES - 1))
                    && last_pass;
        end
    end

endmodule

// ==== src/feed_strobes.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module feed_strobes (
    input  logic                     clk,
    input  logic                     rst_n,
    input  conv_ctrl_pkg::phase_t    next_phase,
    input  conv_ctrl_pkg::step_t     step,
    input  conv_ctrl_pkg::tile_t     tile,
    output logic                     load_wgt,
    output logic                     load_ifm,
    output logic                     ifm_bank,
    output logic                     select_wgt,
    output logic                     reset_pe,
    output logic [1:0]               ifm_shift_en,
    output conv_ctrl_pkg::col_mask_t wgt_shift_en
);
    import conv_ctrl_pkg::*;

    logic       in_window;
    logic       bank_d;
    logic       load_ifm_d;
    logic       reset_pe_d;
    logic [1:0] ifm_shift_d;
    col_mask_t  wgt_shift_d;

    assign in_window = (next_phase == FIRST_TILE) || (next_phase == STREAM);

    always_comb begin
        bank_d      = 1'b0;
        load_ifm_d  = 1'b0;
        reset_pe_d  = (next_phase == DRAIN);
        ifm_shift_d = 2'b00;
        wgt_shift_d = '0;
        if (next_phase == LOAD_WEIGHT) begin
            wgt_shift_d = '1;
        end else if (in_window) begin
            bank_d     = ((step == '0) && (tile != '0)) ? !ifm_bank : ifm_bank;
            load_ifm_d = (step < step_t'(`CC_LOAD_CYCLES));
            reset_pe_d = (step == step_t'(`CC_WINDOW_CYCLES - 1));
            ifm_shift_d         = 2'b11; // The idle bank keeps shifting into the array.
            ifm_shift_d[bank_d] = (step <= step_t'(`CC_LOAD_CYCLES + 1));
            for (int i = 0; i < `CC_SYSTOLIC_SIZE; i++) begin
                wgt_shift_d[i] = (step >= step_t'(i)) && (step < step_t'(`CC_LOAD_CYCLES + i));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_wgt     <= 1'b0;
            load_ifm     <= 1'b0;
            ifm_bank     <= 1'b0;
            select_wgt   <= 1'b0;
            reset_pe     <= 1'b0;
            ifm_shift_en <= 2'b00;
            wgt_shift_en <= '0;
        end else begin
            load_wgt     <= (next_phase == LOAD_WEIGHT);
            select_wgt   <= (next_phase == LOAD_WEIGHT);
            load_ifm     <= load_ifm_d;
            ifm_bank     <= bank_d;
            reset_pe     <= reset_pe_d;
            ifm_shift_en <= ifm_shift_d;
            wgt_shift_en <= wgt_shift_d;
        end
    end

endmodule

// ==== src/write_strobes.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module write_strobes (
    input  logic                     clk,
    input  logic                     rst_n,
    input  conv_ctrl_pkg::phase_t    next_phase,
    input  conv_ctrl_pkg::step_t     step,
    input  conv_ctrl_pkg::tile_t     tile,
    input  conv_ctrl_pkg::wgt_size_t wgt_size,
    output logic                     write_out_pe_en,
    output logic                     fifo_wr_en,
    output logic                     fifo_rd_en,
    output logic                     write_ofm_en
);
    import conv_ctrl_pkg::*;

    logic wr_window;
    logic wr_active;
    logic pair_q;
    logic pair_d;

    // Each STREAM window and the DRAIN write back the tile before them.
    assign wr_window = (next_phase == STREAM) || (next_phase == DRAIN);
    assign wr_active = wr_window && (step < step_t'(wgt_size));

    always_comb begin
        pair_d = pair_q;
        if (wr_window && (step == '0)) begin
            pair_d = ((next_phase == STREAM) && (tile == tile_t'(1))) ? 1'b0 : !pair_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_q          <= 1'b0;
            write_out_pe_en <= 1'b0;
            fifo_wr_en      <= 1'b0;
            fifo_rd_en      <= 1'b0;
            write_ofm_en    <= 1'b0;
        end else begin
            pair_q          <= pair_d; // High while an odd tile is written back.
            write_out_pe_en <= wr_active;
            fifo_wr_en      <= wr_active;
            fifo_rd_en      <= wr_active && pair_d;
            write_ofm_en    <= wr_active && pair_d;
        end
    end

endmodule

// ==== src/conv_ctrl_top.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module conv_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`CC_WB_AW-1:0]     wb_adr,
    input  logic [`CC_WB_DW-1:0]     wb_dat_w,
    output logic [`CC_WB_DW-1:0]     wb_dat_r,
    output logic                     wb_ack,
    output logic                     load_wgt,
    output logic                     load_ifm,
    output logic                     ifm_bank,
    output logic                     select_wgt,
    output logic                     reset_pe,
    output logic [1:0]               ifm_shift_en,
    output conv_ctrl_pkg::col_mask_t wgt_shift_en,
    output logic                     write_out_pe_en,
    output logic                     fifo_wr_en,
    output logic                     fifo_rd_en,
    output logic                     write_ofm_en,
    output conv_ctrl_pkg::pass_t     filter_pass,
    output logic                     done
);
    import conv_ctrl_pkg::*;

    logic      start;
    logic      busy;
    wgt_size_t wgt_size;
    phase_t    next_phase;
    step_t     step;
    tile_t     tile;

    ctrl_regs u_ctrl_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .busy     (busy),
        .done     (done),
        .start    (start),
        .wgt_size (wgt_size)
    );

    phase_sequencer u_phase_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .next_phase  (next_phase),
        .step        (step),
        .tile        (tile),
        .filter_pass (filter_pass),
        .busy        (busy),
        .done        (done)
    );

    feed_strobes u_feed_strobes (
        .clk          (clk),
        .rst_n        (rst_n),
        .next_phase   (next_phase),
        .step         (step),
        .tile         (tile),
        .load_wgt     (load_wgt),
        .load_ifm     (load_ifm),
        .ifm_bank     (ifm_bank),
        .select_wgt   (select_wgt),
        .reset_pe     (reset_pe),
        .ifm_shift_en (ifm_shift_en),
        .wgt_shift_en (wgt_shift_en)
    );

    write_strobes u_write_strobes (
        .clk             (clk),
        .rst_n           (rst_n),
        .next_phase      (next_phase),
        .step            (step),
        .tile            (tile),
        .wgt_size        (wgt_size),
        .write_out_pe_en (write_out_pe_en),
        .fifo_wr_en      (fifo_wr_en),
        .fifo_rd_en      (fifo_rd_en),
        .write_ofm_en    (write_ofm_en)
    );

endmodule

// ==== tests/conv_ctrl_chk.sv ====
`timescale 1ns/1ps

module conv_ctrl_chk (
    input logic clk,
    input logic rst_n,
    input logic load_wgt,
    input logic load_ifm,
    input logic write_ofm_en,
    input logic fifo_rd_en,
    input logic fifo_wr_en,
    input logic wb_ack,
    input logic done
);
    int fail_cnt = 0;

    a_feed_excl: assert property (@(posedge clk) disable iff (!rst_n) !(load_wgt && load_ifm))
        else begin
            fail_cnt++;
            $error("load_wgt and load_ifm are high together");
        end

    // An OFM write pops the pooling partner and pushes the new result.
    a_pool_pair: assert property (@(posedge clk) disable iff (!rst_n)
                                  write_ofm_en |-> (fifo_rd_en && fifo_wr_en))
        else begin
            fail_cnt++;
            $error("write_ofm_en without both FIFO enables");
        end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("wb_ack held for two cycles");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_cnt++;
            $error("done held for two cycles");
        end

endmodule

bind conv_ctrl_top conv_ctrl_chk u_chk (.*);

// ==== tests/conv_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "conv_ctrl_defs.svh"

module conv_ctrl_tb;
    import conv_ctrl_pkg::*;

    localparam int NUM_RUNS    = 6;
    localparam int PASS_CYCLES = `CC_LOAD_CYCLES + `CC_NO_TILING * `CC_WINDOW_CYCLES
                                 + `CC_DRAIN_CYCLES;
    localparam int BUS_CYCLES  = 120; // Register traffic and idle gaps of one run.
    localparam int TIMEOUT     = 2 * (NUM_RUNS * (`CC_NO_PASS * PASS_CYCLES + BUS_CYCLES) + 50);

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc, wb_stb, wb_we;
    logic [`CC_WB_AW-1:0] wb_adr;
    logic [`CC_WB_DW-1:0] wb_dat_w, wb_dat_r;
    logic                 wb_ack, load_wgt, load_ifm, ifm_bank, select_wgt, reset_pe;
    logic [1:0]           ifm_shift_en;
    col_mask_t            wgt_shift_en;
    logic                 write_out_pe_en, fifo_wr_en, fifo_rd_en, write_ofm_en, done;
    pass_t                filter_pass;

    logic [31:0] lcg_state = 32'h33c8_d5e1;
    logic [31:0] rd;
    int          errs = 0;
    int          checks = 0;
    int          cycles = 0;
    int          ws;
    int          n_lw, n_li, n_rp, n_sw, n_wo, n_fw, n_fr, n_ow, n_done;
    int          n_bank, n_cur, n_oth, win_idx;
    int          wstep;
    logic        in_win = 1'b0;
    logic        li_q = 1'b0;
    logic        cur_bank;
    int          first [`CC_SYSTOLIC_SIZE];
    int          highs [`CC_SYSTOLIC_SIZE];

    conv_ctrl_top u_conv_ctrl_top (.*);

    always #20 clk = !clk;

    function automatic int rand_range(input int lo, input int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'({16'd0, lcg_state[23:8]}) % (hi - lo + 1);
    endfunction

    task automatic check_word(input string name, input logic [`CC_WB_DW-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_wgt_size(input string name, input wgt_size_t got, exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_pass(input string name, input pass_t got, exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        checks++;
        if (got != exp) begin
            errs++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Called 2 ns after a rising edge; returns at the same point of the acked cycle.
    task automatic bus_xfer(input reg_addr_t addr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #2;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: no finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    // Strobes are registered, so the falling edge sees settled values.
    always @(negedge clk) begin
        if (rst_n) begin
            n_lw += int'(load_wgt);
            n_li += int'(load_ifm);
            n_rp += int'(reset_pe);
            n_sw += int'(select_wgt);
            n_wo += int'(write_out_pe_en);
            n_fw += int'(fifo_wr_en);
            n_fr += int'(fifo_rd_en);
            n_ow += int'(write_ofm_en);
            if (load_ifm && !li_q) begin
                in_win   = 1'b1; // Every tile window opens with load_ifm.
                wstep    = 0;
                cur_bank = (win_idx % 2) == 1; // Banks alternate from 0 over the windows.
                n_bank   = 0;
                n_cur    = 0;
                n_oth    = 0;
                for (int i = 0; i < `CC_SYSTOLIC_SIZE; i++) begin
                    first[i] = -1;
                    highs[i] = 0;
                end
            end else if (in_win) begin
                wstep++;
            end
            if (in_win) begin
                for (int i = 0; i < `CC_SYSTOLIC_SIZE; i++) begin
                    if (wgt_shift_en[i]) begin
                        if (first[i] < 0) first[i] = wstep;
                        highs[i]++;
                    end
                end
                n_bank += int'(ifm_bank == cur_bank);
                n_cur  += int'(ifm_shift_en[cur_bank] == (wstep <= `CC_LOAD_CYCLES + 1));
                n_oth  += int'(ifm_shift_en[!cur_bank]);
                if (wstep == `CC_WINDOW_CYCLES - 1) begin
                    for (int i = 0; i < `CC_SYSTOLIC_SIZE; i++) begin
                        check_count($sformatf("wgt_shift_en[%0d] rise", i), first[i] - first[0], i);
                        check_count($sformatf("wgt_shift_en[%0d] high", i), highs[i],
                                    `CC_LOAD_CYCLES);
                    end
                    check_count("ifm_bank", n_bank, `CC_WINDOW_CYCLES);
                    check_count("ifm_shift_en loading bank", n_cur, `CC_WINDOW_CYCLES);
                    check_count("ifm_shift_en idle bank", n_oth, `CC_WINDOW_CYCLES);
                    win_idx++;
                    in_win = 1'b0;
                end
            end
            li_q = load_ifm;
            if (done) begin
                n_done++;
                check_pass("filter_pass", filter_pass, pass_t'(`CC_NO_PASS));
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        bus_xfer(REG_WGT_SIZE, 1'b0, 32'h0, rd);
        check_wgt_size("wgt_size", wgt_size_t'(rd), wgt_size_t'(`CC_SYSTOLIC_SIZE));
        bus_xfer(REG_CTRL, 1'b0, 32'h0, rd);
        check_word("ctrl", rd, 32'h0);
        bus_xfer(REG_RSVD, 1'b0, 32'h0, rd);
        check_word("reserved", rd, 32'h0);
        for (int run = 0; run < NUM_RUNS; run++) begin
            ws = rand_range(1, `CC_SYSTOLIC_SIZE);
            // Upper bits are random so that the field mask is exercised.
            bus_xfer(REG_WGT_SIZE, 1'b1, (lcg_state & 32'hffff_fff8) | 32'(ws), rd);
            bus_xfer(REG_WGT_SIZE, 1'b0, 32'h0, rd);
            check_wgt_size("wgt_size", wgt_size_t'(rd), wgt_size_t'(ws));
            check_word("wgt_size upper bits", rd >> $bits(wgt_size_t), 32'h0);
            idle_cycles(rand_range(0, 7));
            {n_lw, n_li, n_rp, n_sw, n_wo, n_fw, n_fr, n_ow, n_done, win_idx} = '0;
            bus_xfer(REG_CTRL, 1'b1, 32'h1, rd);
            idle_cycles(rand_range(2, 20));
            bus_xfer(REG_CTRL, 1'b1, 32'h1, rd); // Ignored while busy.
            bus_xfer(REG_STATUS, 1'b0, 32'h0, rd);
            check_word("status busy", rd, 32'h1);
            while (n_done == 0) idle_cycles(1);
            idle_cycles(3);
            bus_xfer(REG_STATUS, 1'b0, 32'h0, rd);
            check_word("status done", rd, 32'h2);
            check_count("done pulses", n_done, 1);
            check_count("load_wgt", n_lw, `CC_NO_PASS * `CC_LOAD_CYCLES);
            check_count("select_wgt", n_sw, `CC_NO_PASS * `CC_LOAD_CYCLES);
            check_count("load_ifm", n_li, `CC_NO_PASS * `CC_NO_TILING * `CC_LOAD_CYCLES);
            check_count("reset_pe", n_rp, `CC_NO_PASS * (`CC_NO_TILING + `CC_DRAIN_CYCLES));
            check_count("write_out_pe_en", n_wo, `CC_NO_PASS * `CC_NO_TILING * ws);
            check_count("fifo_wr_en", n_fw, `CC_NO_PASS * `CC_NO_TILING * ws);
            check_count("fifo_rd_en", n_fr, `CC_NO_PASS * `CC_NO_TILING * ws / 2);
            check_count("write_ofm_en", n_ow, `CC_NO_PASS * `CC_NO_TILING * ws / 2);
            bus_xfer(REG_STATUS, 1'b1, 32'h2, rd);
            bus_xfer(REG_STATUS, 1'b0, 32'h0, rd);
            check_word("status cleared", rd, 32'h0);
        end
        $display("Checks %0d, value errors %0d, assertion errors %0d",
                 checks, errs, u_conv_ctrl_top.u_chk.fail_cnt);
        if ((errs == 0) && (u_conv_ctrl_top.u_chk.fail_cnt == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/conv_ctrl_pkg.sv
src/ctrl_regs.sv
src/phase_sequencer.sv
src/feed_strobes.sv
src/write_strobes.sv
src/conv_ctrl_top.sv
tests/conv_ctrl_chk.sv
tests/conv_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module conv_ctrl_tb \
    -f project.f --Mdir obj_dir -o conv_ctrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/conv_ctrl_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1
